/* exeDown.f */
exePipePkg.sv
exeIsaPkg.sv
exeStageIf.sv
stageLatch.sv
operandForward.sv
aluCore.sv
memAccessPlan.sv
exceptionCheck.sv
exeDownTop.sv
tbClockGen.sv
exeDownTb.sv

/* runSim.sh */
#!/bin/sh
# compile and run the exeDown testbench; exit status follows the simulation
verilator --binary --timing -f exeDown.f --top-module exeDownTb -o exeDownSim \
    && ./obj_dir/exeDownSim \
    || exit 1

/* exeDownTb.sv */
`timescale 1ns/1ns

module exeDownTb;
    import exePipePkg::*;
    import exeIsaPkg::*;

    localparam int ResetCycles = 10;
    localparam int AluCount    = 200;
    localparam int HoldCycles  = 4;
    localparam int HsCount     = 100;
    // sum of the worst-case length of every test
    localparam int TestCycles  = (ResetCycles + 3) + (AluCount + 8) + 4 * (HoldCycles + 4)
                               + (3 * 4 + 5 * 4 + 4) + (4 * 4 + 4 + 2) + 6 * HsCount + 20;
    localparam int CycleLimit  = TestCycles + 200;

    typedef struct {
        regNum_t   writeNum;
        aluOp_t    aluOp;
        word_t     oprand0, oprand1, readData0, readData1;
        logic      oprand0IsReg, oprand1IsReg;
        fwdSel_t   fwdSel0, fwdSel1;
        logic      memReq, memWr;
        memOp_u    memOp;
        trapKind_t trapKind;
        logic      inException;
        excCode_t  inExcCode;
        word_t     vAddr, fwdExe, fwdMem;
    } inst_t;

    typedef struct {
        word_t    aluRes;
        byteEn_t  memEn;
        word_t    storeData;
        logic     hasExc;
        excCode_t code;
        word_t    badVAddr;
    } exp_t;

    logic clk, rst;
    logic inValid, outAllowin, flush;
    inst_t drvInst;                 // fields on the DUT inputs
    word_t wbVal;
    logic inAllowin, outValid, memReq, memWr, hasException;
    regNum_t writeNum;
    word_t aluRes, storeData, badVAddr;
    byteEn_t memEnable;
    excCode_t excCode;

    // model state
    logic heldValid, hsDone;
    inst_t heldRec;
    word_t rngState, stallState;
    word_t acceptedQ[$];
    word_t retiredQ[$];
    string testName;
    int cycleCount;

    tbClockGen #(.PeriodNs(100)) u_clockGen (.clk_o(clk));

    exeDownTop u_exeDownTop (
        .clk(clk), .rst(rst),
        .inValid_i(inValid), .outAllowin_i(outAllowin), .flush_i(flush),
        .writeNum_i(drvInst.writeNum), .aluOp_i(drvInst.aluOp),
        .oprand0_i(drvInst.oprand0), .oprand1_i(drvInst.oprand1),
        .readData0_i(drvInst.readData0), .readData1_i(drvInst.readData1),
        .oprand0IsReg_i(drvInst.oprand0IsReg), .oprand1IsReg_i(drvInst.oprand1IsReg),
        .fwdSel0_i(drvInst.fwdSel0), .fwdSel1_i(drvInst.fwdSel1),
        .memReq_i(drvInst.memReq), .memWr_i(drvInst.memWr), .memOp_i(drvInst.memOp),
        .trapKind_i(drvInst.trapKind), .inException_i(drvInst.inException),
        .inExcCode_i(drvInst.inExcCode), .vAddr_i(drvInst.vAddr),
        .fwdExe_i(drvInst.fwdExe), .fwdMem_i(drvInst.fwdMem), .fwdWb_i(wbVal),
        .inAllowin_o(inAllowin), .outValid_o(outValid), .writeNum_o(writeNum),
        .aluRes_o(aluRes), .memReq_o(memReq), .memWr_o(memWr),
        .memEnable_o(memEnable), .storeData_o(storeData),
        .hasException_o(hasException), .excCode_o(excCode), .badVAddr_o(badVAddr)
    );

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    function automatic word_t xorshift32(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t randWord();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    function automatic inst_t blankInst();
        inst_t r;
        r = '{writeNum: '0, aluOp: AluAdd, trapKind: TrapNone, inExcCode: ExcNone,
              memOp: '0, fwdSel0: '0, fwdSel1: '0, default: '0};
        return r;
    endfunction

    // alu op on two immediates
    function automatic inst_t randInst();
        inst_t r;
        r          = blankInst();
        r.writeNum = regNum_t'(randWord());
        r.aluOp    = aluOp_t'(4'(randWord() % 14));
        r.oprand0  = randWord();
        r.oprand1  = randWord();
        return r;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic word_t regPick(fwdSel_t sel, word_t rd, word_t exe, word_t mem,
                                      word_t wb);
        case (sel)
            4'b0001: return rd;
            4'b0010: return exe;
            4'b0100: return mem;
            4'b1000: return wb;
            default: return '0;
        endcase
    endfunction

    function automatic exp_t refModel(inst_t r, word_t wb);
        exp_t e;
        word_t reg1, a, b, addr;
        longint wide;
        logic ov, trapHit, misal, isHalf, isWord;
        logic [1:0] off;
        reg1 = regPick(r.fwdSel1, r.readData1, r.fwdExe, r.fwdMem, wb);
        a = r.oprand0IsReg ? regPick(r.fwdSel0, r.readData0, r.fwdExe, r.fwdMem, wb) : r.oprand0;
        b = r.oprand1IsReg ? reg1 : r.oprand1;
        case (r.aluOp)
            AluAdd, AluAddu: e.aluRes = a + b;
            AluSub, AluSubu: e.aluRes = a - b;
            AluAnd:  e.aluRes = a & b;
            AluOr:   e.aluRes = a | b;
            AluXor:  e.aluRes = a ^ b;
            AluNor:  e.aluRes = ~a & ~b;
            AluSlt:  e.aluRes = {31'b0, $signed(a) < $signed(b)};
            AluSltu: e.aluRes = {31'b0, a < b};
            AluSll:  e.aluRes = b << a[4:0];
            AluSrl:  e.aluRes = b >> a[4:0];
            AluSra:  e.aluRes = $signed(b) >>> a[4:0];
            AluLui:  e.aluRes = b << 16;
            default: e.aluRes = '0;
        endcase
        wide = 0;
        if (r.aluOp == AluAdd) wide = longint'($signed(a)) + longint'($signed(b));
        if (r.aluOp == AluSub) wide = longint'($signed(a)) - longint'($signed(b));
        ov = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
        case (r.trapKind)
            TrapEq:  trapHit = e.aluRes == 32'd0;
            TrapNe:  trapHit = e.aluRes != 32'd0;
            TrapLt:  trapHit = e.aluRes[0] == 1'b1;
            TrapGe:  trapHit = e.aluRes[0] == 1'b0;
            default: trapHit = 1'b0;
        endcase
        addr = a + r.oprand1;
        off = addr[1:0];
        e.memEn = FullEnable;
        e.storeData = reg1;
        if (r.memWr) begin
            isHalf = r.memOp.store == StoreH;
            isWord = r.memOp.store == StoreW;
            if (r.memOp.store == StoreB) begin
                e.memEn = byteEn_t'(4'b0001 << off);
                e.storeData = {4{reg1[7:0]}};
            end else if (isHalf) begin
                e.memEn = (off < 2'd2) ? 4'b0011 : 4'b1100;
                e.storeData = {2{reg1[15:0]}};
            end
        end else begin
            isHalf = (r.memOp.load == LoadH) || (r.memOp.load == LoadHu);
            isWord = r.memOp.load == LoadW;
        end
        misal = r.memReq && ((isHalf && off[0]) || (isWord && off != 2'd0));
        if (r.inException) e.code = r.inExcCode;
        else if (ov) e.code = ExcOv;
        else if (trapHit) e.code = ExcTrap;
        else if (misal) e.code = r.memWr ? ExcAdES : ExcAdEL;
        else e.code = ExcNone;
        e.hasExc = r.inException || ov || trapHit || misal;
        e.badVAddr = r.inException ? r.vAddr : e.aluRes;
        return e;
    endfunction

    task automatic checkEq(string what, logic [31:0] expVal, logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("ERROR %s %s: expected %h, actual %h", testName, what, expVal, actVal);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // compare then track the handshake
    always @(posedge clk) begin
        exp_t e;
        logic leaving;
        if (!rst) begin
            heldValid = 1'b0;
        end else begin
            checkEq("outValid", 32'(heldValid), 32'(outValid));
            checkEq("inAllowin", 32'(!heldValid || outAllowin), 32'(inAllowin));
            if (heldValid) begin
                e = refModel(heldRec, wbVal);
                checkEq("writeNum", 32'(heldRec.writeNum), 32'(writeNum));
                checkEq("aluRes", e.aluRes, aluRes);
                checkEq("memReq", 32'(heldRec.memReq), 32'(memReq));
                checkEq("memWr", 32'(heldRec.memWr), 32'(memWr));
                checkEq("memEnable", 32'(e.memEn), 32'(memEnable));
                if (heldRec.memReq && heldRec.memWr) checkEq("storeData", e.storeData, storeData);
                checkEq("hasException", 32'(e.hasExc), 32'(hasException));
                checkEq("excCode", 32'(e.code), 32'(excCode));
                checkEq("badVAddr", e.badVAddr, badVAddr);
            end else begin
                checkEq("memReq empty", 32'd0, 32'(memReq));
                checkEq("hasException empty", 32'd0, 32'(hasException));
            end
            leaving = heldValid && outAllowin;
            if (leaving) retiredQ.push_back(aluRes);
            if (flush) begin
                heldValid = 1'b0;
            end else if (inValid && (!heldValid || outAllowin)) begin
                heldRec = drvInst;
                heldValid = 1'b1;
                e = refModel(drvInst, wbVal);
                acceptedQ.push_back(e.aluRes);
            end else if (leaving) begin
                heldValid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Test %s did not finish within %0d cycles", testName, CycleLimit);
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    task automatic sendInst(inst_t r);
        @(negedge clk);
        drvInst = r;
        inValid = 1'b1;
        @(posedge clk);
        while (!inAllowin) @(posedge clk);  // wait for acceptance
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(negedge clk);
            inValid = 1'b0;
        end
    endtask

    task automatic setAllowin(logic v);
        @(negedge clk);
        inValid = 1'b0;
        outAllowin = v;
    endtask

    initial begin
        inst_t r;
        word_t w;
        rngState = 32'd87;
        stallState = 32'd87;
        cycleCount = 0;
        rst = 1'b0;
        inValid = 1'b0;
        outAllowin = 1'b1;
        flush = 1'b0;
        wbVal = '0;
        hsDone = 1'b0;
        drvInst = blankInst();
        testName = "reset";
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        idle(2);

        testName = "alu";
        r = blankInst();
        r.oprand0 = 32'h7fff_ffff;
        r.oprand1 = 32'd1;
        sendInst(r);              // signed overflow
        r.aluOp = AluAddu;
        sendInst(r);
        r.aluOp = AluSub;
        r.oprand0 = 32'h8000_0000;
        sendInst(r);
        for (int i = 0; i < AluCount; i++) sendInst(randInst());
        idle(2);

        testName = "forward";
        for (int s = 0; s < 4; s++) begin
            setAllowin(1'b0);
            r = blankInst();
            r.aluOp = AluAddu;
            r.oprand0IsReg = 1'b1;
            r.fwdSel0 = fwdSel_t'(4'b0001 << s);
            r.readData0 = randWord();
            r.fwdExe = randWord();
            r.fwdMem = randWord();
            r.oprand1IsReg = 1'b1;
            r.fwdSel1 = 4'b0001;
            r.readData1 = randWord();
            sendInst(r);
            for (int h = 0; h < HoldCycles; h++) begin
                @(negedge clk);
                inValid = 1'b0;
                wbVal = randWord();           // live value that the result follows
                drvInst.fwdExe = randWord();  // latched copies stay put
                drvInst.fwdMem = randWord();
            end
            setAllowin(1'b1);
            idle(1);
        end

        testName = "memory";
        for (int m = 0; m < 8; m++) begin
            for (int off = 0; off < 4; off++) begin
                r = blankInst();
                r.aluOp = AluAddu;
                r.memReq = 1'b1;
                r.memWr = m < 3;
                if (m < 3) r.memOp.store = storeMode_t'(4'(m));
                else r.memOp.load = loadMode_t'(4'(m - 3));
                w = randWord();
                r.oprand0IsReg = 1'b1;
                r.fwdSel0 = 4'b0001;
                r.readData0 = {w[31:2], 2'(off)};
                r.oprand1 = randWord() & 32'hffff_fffc;
                r.fwdSel1 = 4'b0001;    // rt is the store data
                r.readData1 = randWord();
                sendInst(r);
            end
        end
        idle(2);

        testName = "trap";
        for (int k = 1; k < 5; k++) begin
            for (int t = 0; t < 4; t++) begin
                r = blankInst();
                r.trapKind = trapKind_t'(3'(k));
                r.aluOp = (k < 3) ? AluSubu : AluSlt;
                w = randWord();
                r.oprand0 = {t[1], w[30:0]};  // sign bits set the slt outcome
                w = randWord();
                r.oprand1 = t[0] ? r.oprand0 : {~t[1], w[30:0]};
                sendInst(r);
            end
        end
        // every other cause present too
        for (int t = 0; t < 4; t++) begin
            r = blankInst();
            r.oprand0 = 32'h7fff_ffff;
            r.oprand1 = 32'(t + 1);
            r.memReq = 1'b1;
            r.memWr = 1'b1;
            r.memOp.store = StoreW;
            r.trapKind = TrapNe;
            r.inException = 1'b1;
            r.inExcCode = t[0] ? ExcAdEL : ExcTrap;
            r.vAddr = randWord();
            sendInst(r);
        end
        idle(2);

        //////////////////////////////
        // handshake under back-pressure
        //////////////////////////////
        testName = "handshake";
        acceptedQ.delete();
        retiredQ.delete();
        fork
            begin
                for (int i = 0; i < HsCount; i++) begin
                    idle(int'(randWord() % 3));
                    sendInst(randInst());
                end
                idle(1);
                hsDone = 1'b1;
            end
            begin
                while (!hsDone) begin
                    @(negedge clk);
                    stallState = xorshift32(stallState);
                    outAllowin = stallState[1:0] != 2'b00;  // low about a quarter of the time
                end
            end
        join
        setAllowin(1'b1);
        while (outValid) @(posedge clk);
        idle(1);
        checkEq("retired count", 32'(acceptedQ.size()), 32'(retiredQ.size()));
        foreach (acceptedQ[i]) checkEq("retired order", acceptedQ[i], retiredQ[i]);

        testName = "flush";
        setAllowin(1'b0);
        sendInst(randInst());
        @(negedge clk);
        inValid = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        outAllowin = 1'b1;
        sendInst(randInst());
        idle(2);

        testName = "midReset";
        setAllowin(1'b0);
        sendInst(randInst());
        @(negedge clk);
        inValid = 1'b0;
        rst = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b1;
        outAllowin = 1'b1;
        idle(3);

        $display("Regression passed");
        $finish;
    end

endmodule

/* tbClockGen.sv */
`timescale 1ns/1ns

module tbClockGen #(
    parameter int PeriodNs = 100
) (
    output logic clk_o
);
    initial clk_o = 1'b0;

    always #(PeriodNs / 2) clk_o = ~clk_o;  // half period high, half low

endmodule

/* exeDownTop.sv */
`timescale 1ns/1ns

module exeDownTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid_i,
    input  logic                  outAllowin_i,
    input  logic                  flush_i,
    input  exePipePkg::regNum_t   writeNum_i,
    input  exeIsaPkg::aluOp_t     aluOp_i,
    input  exePipePkg::word_t     oprand0_i, oprand1_i,
    input  exePipePkg::word_t     readData0_i, readData1_i,
    input  logic                  oprand0IsReg_i, oprand1IsReg_i,
    input  exePipePkg::fwdSel_t   fwdSel0_i, fwdSel1_i,
    input  logic                  memReq_i, memWr_i,
    input  exeIsaPkg::memOp_u     memOp_i,
    input  exeIsaPkg::trapKind_t  trapKind_i,
    input  logic                  inException_i,
    input  exeIsaPkg::excCode_t   inExcCode_i,
    input  exePipePkg::word_t     vAddr_i,
    input  exePipePkg::word_t     fwdExe_i, fwdMem_i,
    input  exePipePkg::word_t     fwdWb_i,        // live write-back result
    output logic                  inAllowin_o,
    output logic                  outValid_o,
    output exePipePkg::regNum_t   writeNum_o,
    output exePipePkg::word_t     aluRes_o,
    output logic                  memReq_o,
    output logic                  memWr_o,
    output exePipePkg::byteEn_t   memEnable_o,
    output exePipePkg::word_t     storeData_o,
    output logic                  hasException_o,
    output exeIsaPkg::excCode_t   excCode_o,
    output exePipePkg::word_t     badVAddr_o
);
    import exePipePkg::*;

    word_t src0, src1, fwdStore;
    logic  overflow;
    logic  misaligned;

    exeStageIf stage ();

    stageLatch u_stageLatch (.*);

    operandForward u_operandForward (.*, .src0_o(src0), .src1_o(src1), .fwdStore_o(fwdStore));

    aluCore u_aluCore (.*, .src0_i(src0), .src1_i(src1), .overflow_o(overflow));

    memAccessPlan u_memAccessPlan (.*, .src0_i(src0), .fwdStore_i(fwdStore),
                                   .misaligned_o(misaligned));

    exceptionCheck u_exceptionCheck (.*, .aluRes_i(aluRes_o), .overflow_i(overflow),
                                     .misaligned_i(misaligned));

    // straight from the latch
    assign outValid_o = stage.hasData;
    assign writeNum_o = stage.writeNum;
    assign memReq_o   = stage.memReq;
    assign memWr_o    = stage.memWr;

endmodule

/* exceptionCheck.sv */
`timescale 1ns/1ns

module exceptionCheck (
    exeStageIf.consumer          stage,
    input  exePipePkg::word_t    aluRes_i,
    input  logic                 overflow_i,
    input  logic                 misaligned_i,
    output logic                 hasException_o,
    output exeIsaPkg::excCode_t  excCode_o,
    output exePipePkg::word_t    badVAddr_o
);
    import exeIsaPkg::*;

    logic trapHit;

    // lt/ge kinds run slt or sltu, result in bit 0
    always_comb begin
        case (stage.trapKind)
            TrapEq:  trapHit = aluRes_i == '0;
            TrapNe:  trapHit = aluRes_i != '0;
            TrapLt:  trapHit = aluRes_i[0];
            TrapGe:  trapHit = !aluRes_i[0];
            default: trapHit = 1'b0;
        endcase
    end

    //////////////////////////////
    // priority encode
    //////////////////////////////
    always_comb begin
        if (stage.inException) begin
            excCode_o = stage.inExcCode;   // older cause wins
        end else if (overflow_i) begin
            excCode_o = ExcOv;
        end else if (trapHit) begin
            excCode_o = ExcTrap;
        end else if (misaligned_i) begin
            excCode_o = stage.memWr ? ExcAdES : ExcAdEL;
        end else begin
            excCode_o = ExcNone;
        end
    end

    assign hasException_o = stage.inException || overflow_i || trapHit || misaligned_i;
    assign badVAddr_o     = stage.inException ? stage.vAddr : aluRes_i;

endmodule

/* memAccessPlan.sv */
`timescale 1ns/1ns

module memAccessPlan (
    exeStageIf.consumer          stage,
    input  exePipePkg::word_t    src0_i,
    input  exePipePkg::word_t    fwdStore_i,
    output exePipePkg::byteEn_t  memEnable_o,
    output exePipePkg::word_t    storeData_o,
    output logic                 misaligned_o
);
    import exePipePkg::*;
    import exeIsaPkg::*;

    logic [1:0] offset;
    byteEn_t    storeEnable;
    logic       halfAccess;
    logic       wordAccess;

    // only the low bits of base + imm matter here
    assign offset = src0_i[1:0] + stage.oprand1[1:0];

    //////////////////////////////
    // store lanes and data
    //////////////////////////////
    always_comb begin
        storeEnable = FullEnable;
        storeData_o = fwdStore_i;
        case (stage.memOp.store)
            StoreB: begin
                storeEnable = byteEn_t'(4'b0001 << offset);
                storeData_o = {4{fwdStore_i[7:0]}};
            end
            StoreH: begin
                storeEnable = offset[1] ? 4'b1100 : 4'b0011;
                storeData_o = {2{fwdStore_i[15:0]}};
            end
            default: ;  // word, all lanes
        endcase
    end

    // access size, read through the view matching the direction
    always_comb begin
        if (stage.memWr) begin
            halfAccess = stage.memOp.store == StoreH;
            wordAccess = stage.memOp.store == StoreW;
        end else begin
            halfAccess = stage.memOp.load inside {LoadH, LoadHu};
            wordAccess = stage.memOp.load == LoadW;
        end
    end

    assign memEnable_o  = stage.memWr ? storeEnable : FullEnable; // loads fetch the whole word
    assign misaligned_o = stage.memReq &&
                          ((halfAccess && offset[0]) || (wordAccess && offset != 2'b00));

endmodule

/* aluCore.sv */
`timescale 1ns/1ns

module aluCore (
    exeStageIf.consumer        stage,
    input  exePipePkg::word_t  src0_i,
    input  exePipePkg::word_t  src1_i,
    output exePipePkg::word_t  aluRes_o,
    output logic               overflow_o
);
    import exePipePkg::*;
    import exeIsaPkg::*;

    localparam int Msb = WordWidth - 1;

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    logic       addOv;
    logic       subOv;

    assign sum   = src0_i + src1_i;
    assign diff  = src0_i - src1_i;
    assign shamt = src0_i[4:0];     // sa or rs low bits

    // same-sign inputs, result sign flipped
    assign addOv = (src0_i[Msb] == src1_i[Msb]) && (sum[Msb] != src0_i[Msb]);
    assign subOv = (src0_i[Msb] != src1_i[Msb]) && (diff[Msb] != src0_i[Msb]);

    assign overflow_o = (stage.aluOp == AluAdd && addOv) || (stage.aluOp == AluSub && subOv);

    always_comb begin
        case (stage.aluOp)
            AluAdd, AluAddu: aluRes_o = sum;
            AluSub, AluSubu: aluRes_o = diff;
            AluAnd:  aluRes_o = src0_i & src1_i;
            AluOr:   aluRes_o = src0_i | src1_i;
            AluXor:  aluRes_o = src0_i ^ src1_i;
            AluNor:  aluRes_o = ~(src0_i | src1_i);
            AluSlt:  aluRes_o = word_t'($signed(src0_i) < $signed(src1_i));
            AluSltu: aluRes_o = word_t'(src0_i < src1_i);
            AluSll:  aluRes_o = src1_i << shamt;
            AluSrl:  aluRes_o = src1_i >> shamt;
            AluSra:  aluRes_o = word_t'($signed(src1_i) >>> shamt);
            AluLui:  aluRes_o = {src1_i[15:0], 16'h0000};
            default: aluRes_o = '0;
        endcase
    end

endmodule

/* operandForward.sv */
`timescale 1ns/1ns

module operandForward (
    exeStageIf.consumer        stage,
    input  exePipePkg::word_t  fwdWb_i,
    output exePipePkg::word_t  src0_o,
    output exePipePkg::word_t  src1_o,
    output exePipePkg::word_t  fwdStore_o
);
    import exePipePkg::*;

    word_t regVal0;
    word_t regVal1;

    // and-or mux, select is one-hot
    function automatic word_t pickReg(fwdSel_t sel, word_t regData, word_t exeVal,
                                      word_t memVal, word_t wbVal);
        return ({WordWidth{sel[FwdReg]}} & regData) |
               ({WordWidth{sel[FwdExe]}} & exeVal)  |
               ({WordWidth{sel[FwdMem]}} & memVal)  |
               ({WordWidth{sel[FwdWb]}}  & wbVal);
    endfunction

    assign regVal0 = pickReg(stage.fwdSel0, stage.readData0, stage.fwdExe, stage.fwdMem, fwdWb_i);
    assign regVal1 = pickReg(stage.fwdSel1, stage.readData1, stage.fwdExe, stage.fwdMem, fwdWb_i);

    assign src0_o = stage.oprand0IsReg ? regVal0 : stage.oprand0;
    assign src1_o = stage.oprand1IsReg ? regVal1 : stage.oprand1;

    // rt for stores, even when src1 is the offset immediate
    assign fwdStore_o = regVal1;

endmodule

/* stageLatch.sv */
`timescale 1ns/1ns

module stageLatch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inValid_i,
    input  logic                  outAllowin_i,
    input  logic                  flush_i,
    input  exePipePkg::regNum_t   writeNum_i,
    input  exeIsaPkg::aluOp_t     aluOp_i,
    input  exePipePkg::word_t     oprand0_i, oprand1_i,
    input  exePipePkg::word_t     readData0_i, readData1_i,
    input  logic                  oprand0IsReg_i, oprand1IsReg_i,
    input  exePipePkg::fwdSel_t   fwdSel0_i, fwdSel1_i,
    input  logic                  memReq_i, memWr_i,
    input  exeIsaPkg::memOp_u     memOp_i,
    input  exeIsaPkg::trapKind_t  trapKind_i,
    input  logic                  inException_i,
    input  exeIsaPkg::excCode_t   inExcCode_i,
    input  exePipePkg::word_t     vAddr_i,
    input  exePipePkg::word_t     fwdExe_i, fwdMem_i,
    output logic                  inAllowin_o,
    exeStageIf.producer           stage
);
    import exeIsaPkg::*;

    logic accept;
    logic clear;

    // single-cycle stage, never stalls internally
    assign inAllowin_o = !stage.hasData || outAllowin_i;
    assign accept      = inValid_i && inAllowin_o;
    assign clear       = flush_i || (inAllowin_o && !inValid_i); // flush, or drained with no refill

    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            stage.hasData      <= 1'b0;
            stage.writeNum     <= '0;
            stage.aluOp        <= AluAdd;
            stage.oprand0      <= '0;
            stage.oprand1      <= '0;
            stage.readData0    <= '0;
            stage.readData1    <= '0;
            stage.oprand0IsReg <= 1'b0;
            stage.oprand1IsReg <= 1'b0;
            stage.fwdSel0      <= '0;
            stage.fwdSel1      <= '0;
            stage.memReq       <= 1'b0;
            stage.memWr        <= 1'b0;
            stage.memOp        <= '0;
            stage.trapKind     <= TrapNone;
            stage.inException  <= 1'b0;
            stage.inExcCode    <= ExcNone;
            stage.vAddr        <= '0;
            stage.fwdExe       <= '0;
            stage.fwdMem       <= '0;
        end else if (accept) begin
            stage.hasData      <= 1'b1;
            stage.writeNum     <= writeNum_i;
            stage.aluOp        <= aluOp_i;
            stage.oprand0      <= oprand0_i;
            stage.oprand1      <= oprand1_i;
            stage.readData0    <= readData0_i;
            stage.readData1    <= readData1_i;
            stage.oprand0IsReg <= oprand0IsReg_i;
            stage.oprand1IsReg <= oprand1IsReg_i;
            stage.fwdSel0      <= fwdSel0_i;
            stage.fwdSel1      <= fwdSel1_i;
            stage.memReq       <= memReq_i;
            stage.memWr        <= memWr_i;
            stage.memOp        <= memOp_i;
            stage.trapKind     <= trapKind_i;
            stage.inException  <= inException_i;
            stage.inExcCode    <= inExcCode_i;
            stage.vAddr        <= vAddr_i;
            stage.fwdExe       <= fwdExe_i;
            stage.fwdMem       <= fwdMem_i;
        end
    end

endmodule

/* exeStageIf.sv */
`timescale 1ns/1ns

interface exeStageIf;
    import exePipePkg::*;
    import exeIsaPkg::*;

    logic      hasData;
    regNum_t   writeNum;
    aluOp_t    aluOp;
    word_t     oprand0, oprand1;      // immediates, or unused when from a register
    word_t     readData0, readData1;  // register file values
    logic      oprand0IsReg, oprand1IsReg;
    fwdSel_t   fwdSel0, fwdSel1;
    logic      memReq, memWr;
    memOp_u    memOp;
    trapKind_t trapKind;
    logic      inException;           // raised by an earlier stage
    excCode_t  inExcCode;
    word_t     vAddr;
    word_t     fwdExe, fwdMem;        // sampled with the instruction

    modport producer (
        output hasData, writeNum, aluOp, oprand0, oprand1, readData0, readData1,
        output oprand0IsReg, oprand1IsReg, fwdSel0, fwdSel1,
        output memReq, memWr, memOp, trapKind, inException, inExcCode, vAddr,
        output fwdExe, fwdMem
    );

    modport consumer (
        input hasData, writeNum, aluOp, oprand0, oprand1, readData0, readData1,
        input oprand0IsReg, oprand1IsReg, fwdSel0, fwdSel1,
        input memReq, memWr, memOp, trapKind, inException, inExcCode, vAddr,
        input fwdExe, fwdMem
    );

endinterface

/* exeIsaPkg.sv */
package exeIsaPkg;

    typedef enum logic [3:0] {
        AluAdd, AluAddu, AluSub, AluSubu,
        AluAnd, AluOr, AluXor, AluNor,
        AluSlt, AluSltu,
        AluSll, AluSrl, AluSra,
        AluLui
    } aluOp_t;

    // conditional trap, judged on the alu result
    typedef enum logic [2:0] {
        TrapNone, TrapEq, TrapNe, TrapLt, TrapGe
    } trapKind_t;

    //////////////////////////////
    // memory access modes
    //////////////////////////////
    typedef enum logic [3:0] {
        LoadB, LoadBu, LoadH, LoadHu, LoadW
    } loadMode_t;

    typedef enum logic [3:0] {
        StoreB, StoreH, StoreW
    } storeMode_t;

    // same field, meaning depends on memWr
    typedef union packed {
        loadMode_t  load;
        storeMode_t store;
    } memOp_u;

    typedef enum logic [4:0] {
        ExcNone = 5'd0,
        ExcAdEL = 5'd4,     // load or fetch address error
        ExcAdES = 5'd5,
        ExcOv   = 5'd12,
        ExcTrap = 5'd13
    } excCode_t;

endpackage

/* exePipePkg.sv */
package exePipePkg;

    localparam int WordWidth = 32;

    typedef logic [WordWidth-1:0] word_t;
    typedef logic [4:0] regNum_t;   // 0 means no write-back

    //////////////////////////////
    // forward select, one-hot
    //////////////////////////////
    typedef logic [3:0] fwdSel_t;

    localparam int FwdReg = 0;  // register file value
    localparam int FwdExe = 1;
    localparam int FwdMem = 2;
    localparam int FwdWb  = 3;  // live, not latched

    // byte lanes
    typedef logic [3:0] byteEn_t;

    localparam byteEn_t FullEnable = 4'b1111;

endpackage
